//--- source/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;                 // one instruction word
	typedef logic [2:0]  lc3b_reg;                  // register index r0..r7

	// standard lc3b opcode field values, rti is not handled here
	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef struct packed
	{
		lc3b_opcode opcode;                         // [15:12]
		lc3b_reg    dr;                             // [11:9] destination
		lc3b_reg    sr1;                            // [8:6] first source
		logic       imm_sel;                        // [5] set means imm5 form
		logic [1:0] pad;                            // [4:3] zero in register form
		lc3b_reg    sr2;                            // [2:0] second source
	} reg_view;

	typedef struct packed
	{
		lc3b_opcode opcode;                         // [15:12]
		lc3b_reg    dr;                             // [11:9] dest, or data source on stores
		lc3b_reg    base;                           // [8:6] base register
		logic [5:0] offset6;                        // [5:0] word or byte offset
	} mem_view;

	// same 16 bits seen as an alu op or as a memory op
	typedef union packed
	{
		reg_view regs;
		mem_view mem;
	} lc3b_instr;

	typedef struct packed
	{
		logic produces_dr;                          // writes dr
		logic need_sr1;                             // reads sr1 / base
		logic need_sr2;                             // reads sr2
		logic need_hsr;                             // store reading dr as data
	} operand_needs;

	localparam lc3b_word NOP_WORD = 16'h0000;      // br with nzp clear, never taken

	localparam logic [2:0] BRANCH_SHADOW = 3'd5;   // countdown start value

endpackage : lc3b_types

//--- source/dependency_calc.sv
`timescale 1ns/1ps

module dependency_calc
(
	input  lc3b_types::lc3b_word     ir,
	output lc3b_types::operand_needs needs
);

	import lc3b_types::*;

	lc3b_instr instr;                               // decoded view of ir

	assign instr = ir;

	always_comb
	begin
		needs = '0;                                 // branches, jumps, traps read nothing here

		case (instr.regs.opcode)
			op_add, op_and:
			begin
				needs.produces_dr = 1'b1;
				needs.need_sr1    = 1'b1;
				needs.need_sr2    = ~instr.regs.imm_sel;   // only register form reads sr2
			end
			op_not, op_shf:
			begin
				needs.produces_dr = 1'b1;
				needs.need_sr1    = 1'b1;
			end
			op_lea:
				needs.produces_dr = 1'b1;           // pc relative, no register source
			op_ldb, op_ldr, op_ldi:
			begin
				needs.produces_dr = 1'b1;
				needs.need_sr1    = 1'b1;           // base register
			end
			op_stb, op_str, op_sti:
			begin
				needs.need_sr1    = 1'b1;           // base register
				needs.need_hsr    = 1'b1;           // store data lives in dr field
			end
			default:
				needs = '0;
		endcase
	end

	// a store never uses the sr2 slot, its low bits are an offset
	always_comb
	begin
		assert (!(needs.need_sr2 && needs.need_hsr))
		else $error("dependency_calc: sr2 and store data flagged together for %h", ir);
	end

endmodule : dependency_calc

//--- source/bubbler.sv
`timescale 1ns/1ps

module bubbler
(
	input  logic                     clk,
	input  logic                     reset,
	input  lc3b_types::lc3b_word     id_ir,
	input  lc3b_types::lc3b_word     ex_ir,
	input  lc3b_types::operand_needs id_needs,
	input  logic                     branch_enable,
	input  logic                     flow,

	output logic                     bubble,
	output logic                     squash
);

	import lc3b_types::*;

	lc3b_instr  id_instr;                           // word in if/id
	lc3b_instr  ex_instr;                           // word in id/ex
	logic [2:0] count;                              // control transfer countdown
	logic [2:0] count_next;
	logic       taken_q;                            // branch_enable from last flowing edge
	logic       ex_is_load;
	logic       load_use;
	logic       id_is_transfer;
	logic       id_is_br;

	assign id_instr = id_ir;
	assign ex_instr = ex_ir;

	assign ex_is_load = ex_instr.mem.opcode inside {op_ldb, op_ldi, op_ldr};

	assign id_is_br = (id_instr.mem.opcode == op_br);

	// the nop word decodes as br, so keep it from starting a countdown
	assign id_is_transfer = (id_ir != NOP_WORD) &&
		(id_instr.mem.opcode inside {op_br, op_jmp, op_jsr, op_trap});

	// load in ex whose dr is read by the instruction behind it
	always_comb
	begin
		load_use = 1'b0;

		if (ex_is_load)
		begin
			if (id_needs.need_hsr)                  // store checks data and base
			begin
				if ((id_instr.mem.dr == ex_instr.mem.dr) ||
					(id_instr.mem.base == ex_instr.mem.dr))
					load_use = 1'b1;
			end

			if (id_needs.need_sr1 && (id_instr.regs.sr1 == ex_instr.mem.dr))
				load_use = 1'b1;

			if (id_needs.need_sr2 && (id_instr.regs.sr2 == ex_instr.mem.dr))
				load_use = 1'b1;
		end
	end

	// countdown sequencing and the bubble and squash levels
	always_comb
	begin
		count_next = count;
		bubble     = load_use;                      // one bubble is enough for a load
		squash     = 1'b0;

		if ((count == 3'd0) && id_is_transfer)
		begin
			count_next = BRANCH_SHADOW;             // transfer moves on to id/ex this edge
		end
		else if (count > 3'd1)
		begin
			count_next = count - 3'd1;
			bubble     = 1'b1;                      // hold fetch while the target resolves
		end
		else if (count == 3'd1)
		begin
			count_next = 3'd0;
			if (id_is_br)
				squash = taken_q;                   // conditional, use latched result
			else
				squash = 1'b1;                      // unconditional, always drop it
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count   <= 3'd0;
			taken_q <= 1'b0;
		end
		else if (flow)
		begin
			count   <= count_next;
			taken_q <= branch_enable;               // refreshed every flowing edge
		end
	end

	// squash is confined to the last step of the countdown
	squash_at_one: assert property (@(posedge clk) disable iff (reset)
		squash |-> (count == 3'd1))
	else $error("bubbler: squash with counter at %0d", count);

	// counter is only ever loaded with the shadow length and counts down from there
	count_bounded: assert property (@(posedge clk) disable iff (reset)
		count <= BRANCH_SHADOW)
	else $error("bubbler: counter at %0d exceeds shadow", count);

endmodule : bubbler

//--- source/if_id_stage.sv
`timescale 1ns/1ps

module if_id_stage
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 flow,
	input  logic                 bubble,
	input  logic                 squash,
	input  lc3b_types::lc3b_word fetch_ir,

	output lc3b_types::lc3b_word id_ir
);

	import lc3b_types::*;

	always_ff @(posedge clk)
	begin
		if (reset)
			id_ir <= NOP_WORD;                      // start empty
		else if (flow)
		begin
			if (squash)
				id_ir <= NOP_WORD;                  // wrong path word, drop it
			else if (!bubble)
				id_ir <= fetch_ir;                  // normal advance
			// bubble alone keeps the current word for another cycle
		end
	end

endmodule : if_id_stage

//--- source/id_ex_stage.sv
`timescale 1ns/1ps

module id_ex_stage
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 flow,
	input  logic                 bubble,
	input  lc3b_types::lc3b_word id_ir,

	output lc3b_types::lc3b_word ex_ir
);

	import lc3b_types::*;

	always_ff @(posedge clk)
	begin
		if (reset)
			ex_ir <= NOP_WORD;
		else if (flow)
		begin
			if (bubble)
				ex_ir <= NOP_WORD;                  // nothing issues this cycle
			else
				ex_ir <= id_ir;                     // decoded word moves on
		end
	end

	// a memory stall freezes execute
	stall_holds: assert property (@(posedge clk) disable iff (reset)
		!flow |=> $stable(ex_ir))
	else $error("id_ex_stage: ex_ir changed during a stall");

endmodule : id_ex_stage

//--- source/hazard_pipe.sv
`timescale 1ns/1ps

module hazard_pipe
(
	input  logic                 clk,
	input  logic                 reset,
	input  lc3b_types::lc3b_word fetch_ir,
	input  logic                 flow,              // low during a memory stall
	input  logic                 branch_enable,     // condition result from execute

	output logic                 fetch_hold,        // present the same word again
	output lc3b_types::lc3b_word id_ir,
	output lc3b_types::lc3b_word ex_ir,
	output logic                 squash
);

	import lc3b_types::*;

	logic         bubble;
	operand_needs id_needs;                         // sources read by the if/id word

	assign fetch_hold = bubble;                     // a bubble holds if/id, so fetch waits

	if_id_stage if_id_inst
	(
		.clk      (clk),
		.reset    (reset),
		.flow     (flow),
		.bubble   (bubble),
		.squash   (squash),
		.fetch_ir (fetch_ir),
		.id_ir    (id_ir)
	);

	// ex side only needs the load opcode and dr, so one decoder covers it
	dependency_calc id_deps
	(
		.ir    (id_ir),
		.needs (id_needs)
	);

	bubbler bubbler_inst
	(
		.clk           (clk),
		.reset         (reset),
		.id_ir         (id_ir),
		.ex_ir         (ex_ir),
		.id_needs      (id_needs),
		.branch_enable (branch_enable),
		.flow          (flow),
		.bubble        (bubble),
		.squash        (squash)
	);

	id_ex_stage id_ex_inst
	(
		.clk    (clk),
		.reset  (reset),
		.flow   (flow),
		.bubble (bubble),
		.id_ir  (id_ir),
		.ex_ir  (ex_ir)
	);

endmodule : hazard_pipe

//--- dv/hazard_pipe_tb.sv
`timescale 1ns/1ps

module hazard_pipe_tb;

	import lc3b_types::*;

	localparam int SEND_LIMIT   = 64;               // cycles a word may wait at fetch
	localparam int DRAIN_LIMIT  = 48;               // cycles to empty the pipe
	localparam int RANDOM_WORDS = 400;

	typedef struct packed
	{
		logic bubble;                               // also fetch_hold
		logic squash;
	} hazard_levels;

	logic     clk = 1'b0;
	logic     reset;
	lc3b_word fetch_ir;
	logic     flow;
	logic     branch_enable;
	logic     fetch_hold;
	lc3b_word id_ir;
	lc3b_word ex_ir;
	logic     squash;

	lc3b_word     m_id;                             // model of if/id
	lc3b_word     m_ex;                             // model of id/ex
	logic [2:0]   m_count;                          // model countdown
	logic         m_taken;                          // model latched branch result
	logic         m_live = 1'b0;                    // set once the model has seen an edge
	hazard_levels edge_levels;
	hazard_levels cmp_levels;
	hazard_levels dut_levels = '0;                  // dut levels held up to the next edge

	int checks = 0;
	int errors = 0;
	int bubble_edges = 0;
	int squash_edges = 0;
	int stall_edges  = 0;

	always #20 clk = ~clk;                          // 40 ns period

	hazard_pipe hazard_pipe_inst
	(
		.clk           (clk),
		.reset         (reset),
		.fetch_ir      (fetch_ir),
		.flow          (flow),
		.branch_enable (branch_enable),
		.fetch_hold    (fetch_hold),
		.id_ir         (id_ir),
		.ex_ir         (ex_ir),
		.squash        (squash)
	);

	// expected bubble and squash levels for one pipe state
	function automatic hazard_levels expected_hazard(input lc3b_word id_w, input lc3b_word ex_w,
		input logic [2:0] cnt, input logic taken);
		hazard_levels h;
		logic [3:0]   id_op;
		logic [2:0]   ld_dr;
		logic         hit;
		id_op = id_w[15:12];
		ld_dr = ex_w[11:9];                         // load destination
		hit   = 1'b0;
		if (ex_w[15:12] inside {op_ldb, op_ldi, op_ldr})
		begin
			case (id_op)
				op_add, op_and:
					hit = (id_w[8:6] == ld_dr) || (!id_w[5] && (id_w[2:0] == ld_dr));
				op_not, op_shf, op_ldb, op_ldr, op_ldi:
					hit = (id_w[8:6] == ld_dr);     // sr1 or base only
				op_stb, op_str, op_sti:
					hit = (id_w[8:6] == ld_dr) || (id_w[11:9] == ld_dr);
				default:
					hit = 1'b0;
			endcase
		end
		h.bubble = hit || (cnt > 3'd1);
		h.squash = (cnt == 3'd1) && ((id_op != op_br) || taken);
		return h;
	endfunction

	function automatic logic starts_countdown(input lc3b_word w);
		return (w != NOP_WORD) && (w[15:12] inside {op_br, op_jmp, op_jsr, op_trap});
	endfunction

	// cycle model advanced on the same edge as the dut
	always @(posedge clk)
	begin
		m_live = 1'b1;
		if (reset)
		begin
			m_id    = NOP_WORD;
			m_ex    = NOP_WORD;
			m_count = 3'd0;
			m_taken = 1'b0;
		end
		else if (!flow)
			stall_edges++;                          // memory stall holds all state
		else
		begin
			edge_levels = expected_hazard(m_id, m_ex, m_count, m_taken);
			if (dut_levels.bubble)
				bubble_edges++;                     // counted from what the dut showed
			if (dut_levels.squash)
				squash_edges++;
			if (m_count != 3'd0)
				m_count = m_count - 3'd1;
			else if (starts_countdown(m_id))
				m_count = BRANCH_SHADOW;
			m_ex = edge_levels.bubble ? NOP_WORD : m_id;   // uses old if/id word
			if (edge_levels.squash)
				m_id = NOP_WORD;
			else if (!edge_levels.bubble)
				m_id = fetch_ir;
			m_taken = branch_enable;
		end
	end

	// outputs settle after the rising edge and are compared half a cycle later
	always @(negedge clk)
	begin
		if (m_live)
		begin
			cmp_levels = expected_hazard(m_id, m_ex, m_count, m_taken);
			checks += 4;
			assert (fetch_hold == cmp_levels.bubble)
			else
			begin
				errors++;
				$display("Error %0t ns: fetch_hold %b, expected %b", $time, fetch_hold,
					cmp_levels.bubble);
			end
			assert (squash == cmp_levels.squash)
			else
			begin
				errors++;
				$display("Error %0t ns: squash %b, expected %b", $time, squash, cmp_levels.squash);
			end
			assert (id_ir == m_id)
			else
			begin
				errors++;
				$display("Error %0t ns: id_ir %h, expected %h", $time, id_ir, m_id);
			end
			assert (ex_ir == m_ex)
			else
			begin
				errors++;
				$display("Error %0t ns: ex_ir %h, expected %h", $time, ex_ir, m_ex);
			end
			dut_levels.bubble = fetch_hold;
			dut_levels.squash = squash;
		end
	end

	// present one word until fetch takes it and randomize flow in stall mode
	task automatic send_word(input lc3b_word w, input bit stall);
		int waited;
		bit accepted;
		waited   = 0;
		accepted = 1'b0;
		fetch_ir = w;
		while (!accepted && (waited < SEND_LIMIT))
		begin
			if (stall)
			begin
				flow          = (($urandom % 4) != 0);
				branch_enable = (($urandom % 2) == 1);
			end
			accepted = flow && !fetch_hold;         // held level is stable until the edge
			@(negedge clk);
			waited++;
		end
		if (!accepted)
		begin
			errors++;
			$display("timeout: fetch word %h was never accepted by the pipe", w);
		end
	endtask

	task automatic drain_pipe();
		int waited;
		waited   = 0;
		fetch_ir = NOP_WORD;
		flow     = 1'b1;
		while (!((m_id == NOP_WORD) && (m_ex == NOP_WORD) && (m_count == 3'd0)) &&
			(waited < DRAIN_LIMIT))
		begin
			@(negedge clk);
			waited++;
		end
		if (waited >= DRAIN_LIMIT)
		begin
			errors++;
			$display("timeout: pipe did not empty after %0d cycles", DRAIN_LIMIT);
		end
	endtask

	// two words back to back, then count bubble and squash edges until empty
	task automatic run_case(input string name, input lc3b_word first, input lc3b_word second,
		input logic be, input int exp_bubbles, input int exp_squashes);
		int errors_before;
		branch_enable = be;
		drain_pipe();
		errors_before = errors;
		bubble_edges  = 0;
		squash_edges  = 0;
		send_word(first, 1'b0);
		send_word(second, 1'b0);
		drain_pipe();
		checks += 2;
		assert (bubble_edges == exp_bubbles)
		else
		begin
			errors++;
			$display("Error %0t ns: %s gave %0d bubbles, expected %0d", $time, name,
				bubble_edges, exp_bubbles);
		end
		assert (squash_edges == exp_squashes)
		else
		begin
			errors++;
			$display("Error %0t ns: %s gave %0d squashes, expected %0d", $time, name,
				squash_edges, exp_squashes);
		end
		$display("test %s: %0d bubbles, %0d squashes, %0d errors", name, bubble_edges,
			squash_edges, errors - errors_before);
	endtask

	initial
	begin
		lc3b_word word;
		int       errors_before;
		void'($urandom(32'h25b0_6492));
		reset         = 1'b1;
		flow          = 1'b1;
		branch_enable = 1'b0;
		fetch_ir      = NOP_WORD;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		checks += 4;
		assert ((id_ir == NOP_WORD) && (ex_ir == NOP_WORD) && !fetch_hold && !squash)
		else
		begin
			errors++;
			$display("Error %0t ns: state after reset id %h ex %h hold %b squash %b", $time,
				id_ir, ex_ir, fetch_hold, squash);
		end
		$display("test reset: %0d errors", errors);

		run_case("ldr_add_sr1", 16'h6280, 16'h1644, 1'b0, 1, 0);    // ldr r1 then add r3,r1,r4
		run_case("ldr_add_sr2", 16'h6280, 16'h1701, 1'b0, 1, 0);    // add r3,r4,r1
		run_case("ldr_add_indep", 16'h6280, 16'h1705, 1'b0, 0, 0);
		run_case("ldr_add_imm", 16'h6280, 16'h1721, 1'b0, 0, 0);    // imm5 field looks like r1
		run_case("ldb_str_data", 16'h24C0, 16'h7540, 1'b0, 1, 0);   // str data reg is r2
		run_case("br_taken", 16'h0E02, NOP_WORD, 1'b1, 4, 1);
		run_case("br_not_taken", 16'h0E02, NOP_WORD, 1'b0, 4, 0);
		run_case("jmp", 16'hC080, 16'h1705, 1'b0, 4, 1);
		run_case("jsr", 16'h4804, 16'h1705, 1'b0, 4, 1);
		run_case("trap", 16'hF025, 16'h1705, 1'b0, 4, 1);

		// random mix under random memory stalls checked by the model every cycle
		drain_pipe();
		errors_before = errors;
		stall_edges   = 0;
		for (int i = 0; i < RANDOM_WORDS; i++)
		begin
			word = 16'($urandom);
			if (word[15:12] == 4'b1000)
				word[15:12] = op_add;               // rti is not part of this pipe
			send_word(word, 1'b1);
		end
		branch_enable = 1'b0;
		drain_pipe();
		$display("test random_stall: %0d words, %0d stall edges, %0d errors", RANDOM_WORDS,
			stall_edges, errors - errors_before);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule : hazard_pipe_tb

//--- filelist.f
source/lc3b_types.sv
source/dependency_calc.sv
source/bubbler.sv
source/if_id_stage.sv
source/id_ex_stage.sv
source/hazard_pipe.sv
dv/hazard_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the hazard pipeline testbench with verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

TOP=hazard_pipe_tb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	--Mdir "$BUILD_DIR" \
	-o "$TOP" \
	-f filelist.f
status=$?
if [ $status -ne 0 ]; then
	echo "run_sim: verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "run_sim: simulation exited with status $status"
	exit 1
fi

grep -qx "ALL CHECKS PASSED" "$LOG_FILE"
status=$?
if [ $status -ne 0 ]; then
	echo "run_sim: result fail, see $LOG_FILE"
	exit 1
fi

echo "run_sim: result pass"
exit 0
